// File: src/matrix_pkg.sv
// Fixed address map for eight output ports and one remap bit, with bounds held in 1 KB units
package matrix_pkg;

    // ------------------------------
    // Port and address widths
    // ------------------------------
    localparam int NUM_PORTS    = 8;                    // Output ports MI0 to MI7
    localparam int SEL_IDX_W    = $clog2(NUM_PORTS);    // Index bits of a real port
    localparam int DEC_ADDR_LSB = 10;                   // 1 KB decode granule

    typedef logic [3:0]             port_idx_t;         // 0..7 ports, 8 default slave
    typedef logic [NUM_PORTS-1:0]   sel_vec_t;          // One HSEL per output port
    typedef logic [31:DEC_ADDR_LSB] dec_addr_t;         // HADDR[31:10]

    localparam port_idx_t DFLT_PORT = 4'd8;             // Local default slave

    // AHB transfer type and response
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01                                   // Upper bit kept for width only
    } hresp_t;

    // ------------------------------
    // Bundles
    // ------------------------------
    typedef struct packed {
        logic      sel;                                 // HSEL of the input port
        htrans_t   trans;
        dec_addr_t addr;
    } addr_req_t;                                       // 25 bits

    typedef struct packed {
        logic        ready;                             // HREADYOUT
        hresp_t      resp;
        logic [31:0] rdata;
    } slave_rsp_t;                                      // 35 bits

    typedef slave_rsp_t [NUM_PORTS-1:0] slave_rsp_vec_t;

    // ------------------------------
    // Address map, 1 KB units
    // ------------------------------
    localparam dec_addr_t REGION0_LO  = 22'h000000;     // 0x0000_0000
    localparam dec_addr_t REGION0_HI  = 22'h07ffff;     // 0x1fff_ffff
    localparam dec_addr_t REGION1_LO  = 22'h080000;     // 0x2000_0000
    localparam dec_addr_t REGION1_HI  = 22'h0bffff;
    localparam dec_addr_t REGION2_LO  = 22'h0c0000;     // 0x3000_0000
    localparam dec_addr_t REGION2_HI  = 22'h0fffff;
    localparam dec_addr_t REGION3_LO  = 22'h100000;     // 0x4000_0000
    localparam dec_addr_t REGION3_HI  = 22'h17ffff;
    localparam dec_addr_t REGION4_LO  = 22'h200000;     // 0x8000_0000
    localparam dec_addr_t REGION4_HI  = 22'h23ffff;
    localparam dec_addr_t REGION5_LO  = 22'h240000;     // 0x9000_0000
    localparam dec_addr_t REGION5_HI  = 22'h27ffff;
    localparam dec_addr_t REGION6A_LO = 22'h180000;     // 0x6000_0000
    localparam dec_addr_t REGION6A_HI = 22'h1fffff;
    localparam dec_addr_t REGION6B_LO = 22'h280000;     // 0xa000_0000
    localparam dec_addr_t REGION6B_HI = 22'h37ffff;
    localparam dec_addr_t REGION7_LO  = 22'h3c0000;     // 0xf000_0000, 256 KB only
    localparam dec_addr_t REGION7_HI  = 22'h3c00ff;
    localparam dec_addr_t REMAP_HI    = 22'h03ffff;     // Low 256 MB window

    typedef struct packed {
        dec_addr_t lo;
        dec_addr_t hi;
        port_idx_t port;
    } region_t;

    localparam int NUM_REGIONS = 9;

    // Regions do not overlap, so order carries no priority
    localparam region_t REGION_MAP [NUM_REGIONS] = '{
        '{REGION0_LO,  REGION0_HI,  4'd0},
        '{REGION1_LO,  REGION1_HI,  4'd1},
        '{REGION2_LO,  REGION2_HI,  4'd2},
        '{REGION3_LO,  REGION3_HI,  4'd3},
        '{REGION4_LO,  REGION4_HI,  4'd4},
        '{REGION5_LO,  REGION5_HI,  4'd5},
        '{REGION6A_LO, REGION6A_HI, 4'd6},
        '{REGION6B_LO, REGION6B_HI, 4'd6},
        '{REGION7_LO,  REGION7_HI,  4'd7}
    };

endpackage

// File: src/addr_region_decode.sv
// Purely combinational; the idle hold relies on data_port coming from the data-phase register
`timescale 1ns/1ps

module addr_region_decode #(
    parameter matrix_pkg::port_idx_t REMAP_PORT = 4'd1     // Target of the low 256 MB on remap
) (
    // Remap control
    input  logic                  remap,

    // Input stage address phase
    input  matrix_pkg::addr_req_t req,

    // Data-phase port, for the idle hold
    input  matrix_pkg::port_idx_t data_port,

    // Active level of each output stage
    input  matrix_pkg::sel_vec_t  active_in,

    // Decoded address phase
    output matrix_pkg::port_idx_t addr_port,
    output matrix_pkg::sel_vec_t  sel,
    output logic                  dflt_sel,
    output logic                  active
);

    import matrix_pkg::*;

    // ------------------------------
    // Internal signals
    // ------------------------------
    port_idx_t map_port;            // Port from the address map alone
    logic      real_trans;          // NONSEQ or SEQ
    logic      is_port;             // addr_port names a real output port
    logic      remap_hit;           // Address inside the remap window

    // ------------------------------
    // Address map lookup
    // ------------------------------
    assign remap_hit = remap && (req.addr <= REMAP_HI);    // Window starts at zero

    always_comb
    begin
        map_port = DFLT_PORT;                               // Unmapped by default
        if (remap_hit)
        begin
            map_port = REMAP_PORT;                          // Remap overrides static map
        end
        else
        begin
            for (int i = 0; i < NUM_REGIONS; i++)
            begin
                // Inclusive bounds on HADDR[31:10]
                if ((req.addr >= REGION_MAP[i].lo) && (req.addr <= REGION_MAP[i].hi))
                begin
                    map_port = REGION_MAP[i].port;
                end
            end
        end
    end

    // ------------------------------
    // Idle hold
    // ------------------------------
    // Only a real transfer moves the decoder, IDLE and BUSY stay on
    // the port of the transfer now in its data phase
    assign real_trans = req.trans[1];                      // NONSEQ and SEQ share bit 1
    assign addr_port  = real_trans ? map_port : data_port;

    // Indices 9 to 15 never occur and fall back to the default slave
    assign is_port = (addr_port < port_idx_t'(NUM_PORTS));

    // ------------------------------
    // Select decode
    // ------------------------------
    always_comb
    begin
        sel      = '0;
        dflt_sel = 1'b0;
        if (req.sel)                                        // No select without HSEL
        begin
            if (is_port)
            begin
                sel[addr_port[SEL_IDX_W-1:0]] = 1'b1;       // One-hot output select
            end
            else
            begin
                dflt_sel = 1'b1;                            // Local default slave
            end
        end
    end

    // Active level of the addressed stage
    always_comb
    begin
        if (is_port)
        begin
            active = active_in[addr_port[SEL_IDX_W-1:0]];
        end
        else
        begin
            active = 1'b1;                                  // Default slave always active
        end
    end

endmodule

// File: src/matrix_default_slave.sv
// Answers only transfers no output port claims; read data is always zero and writes are dropped
`timescale 1ns/1ps

module matrix_default_slave (
    input  logic                   HCLK,
    input  logic                   HRESETn,        // Synchronous, active low

    // AHB control from the decoder
    input  logic                   dflt_sel,       // HSEL of the default slave
    input  logic                   HREADYS,        // Transfer done on the input side
    input  matrix_pkg::htrans_t    trans,

    // Data-phase return
    output matrix_pkg::slave_rsp_t dflt_rsp
);

    import matrix_pkg::*;

    // ------------------------------
    // Response state
    // ------------------------------
    // Two flops. rsp_wait marks the first ERROR cycle with ready low,
    // rsp_err is set in both ERROR cycles
    logic rsp_wait;
    logic rsp_err;
    logic err_start;                               // Real transfer accepted here

    assign err_start = dflt_sel & HREADYS & trans[1];   // NONSEQ or SEQ only

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            rsp_wait <= 1'b0;
            rsp_err  <= 1'b0;
        end
        else
        begin
            rsp_wait <= err_start;                 // Enter first ERROR cycle
            rsp_err  <= err_start | rsp_wait;      // Stay in ERROR for the second
        end
    end

    // ------------------------------
    // Return bundle
    // ------------------------------
    always_comb
    begin
        dflt_rsp.ready = ~rsp_wait;                // Wait state in cycle one only
        if (rsp_err)
        begin
            dflt_rsp.resp = ERROR;
        end
        else
        begin
            dflt_rsp.resp = OKAY;                  // IDLE and BUSY get zero-wait OKAY
        end
        dflt_rsp.rdata = '0;
    end

endmodule

// File: src/data_phase_select.sv
// HREADYS must be the input-side HREADY and not HREADYOUTS, or the port register can miss a load
`timescale 1ns/1ps

module data_phase_select (
    input  logic                       HCLK,
    input  logic                       HRESETn,     // Synchronous, active low

    // Address phase from the input stage
    input  logic                       HREADYS,     // Transfer done
    input  logic                       req_sel,     // HSEL
    input  matrix_pkg::htrans_t        req_trans,
    input  matrix_pkg::port_idx_t      addr_port,   // Decoded address-phase port

    // Returns from the output stages and the default slave
    input  matrix_pkg::slave_rsp_vec_t slave_rsp,
    input  matrix_pkg::slave_rsp_t     dflt_rsp,

    // Data-phase port and muxed return
    output matrix_pkg::port_idx_t      data_port,
    output logic                       HREADYOUTS,
    output matrix_pkg::hresp_t         HRESPS,
    output logic [31:0]                HRDATAS
);

    import matrix_pkg::*;

    // ------------------------------
    // Data-phase port register
    // ------------------------------
    slave_rsp_t data_rsp;                           // Return of the selected port

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            data_port <= DFLT_PORT;                 // Quiet default slave out of reset
        end
        else if (HREADYS)                           // Holds while the data phase waits
        begin
            if (req_sel && req_trans[1])
            begin
                data_port <= addr_port;             // Real transfer takes its port
            end
            else
            begin
                data_port <= DFLT_PORT;             // Park on the default slave
            end
        end
    end

    // ------------------------------
    // Return mux
    // ------------------------------
    always_comb
    begin
        data_rsp = dflt_rsp;                        // Default slave and unused indices
        if (data_port < port_idx_t'(NUM_PORTS))
        begin
            data_rsp = slave_rsp[data_port[SEL_IDX_W-1:0]];
        end
    end

    assign HREADYOUTS = data_rsp.ready;
    assign HRESPS     = data_rsp.resp;
    assign HRDATAS    = data_rsp.rdata;             // Zero when parked on the default slave

endmodule

// File: src/matrix_decode.sv
// One input port of the bus matrix; the output stages supply active_in and their AHB returns
`timescale 1ns/1ps

module matrix_decode #(
    parameter matrix_pkg::port_idx_t REMAP_PORT = 4'd1     // Low 256 MB target on remap
) (
    // Common AHB signals
    input  logic                       HCLK,
    input  logic                       HRESETn,             // Synchronous, active low

    // Remap control
    input  logic                       remap,

    // Input stage
    input  logic                       HREADYS,             // Transfer done
    input  matrix_pkg::addr_req_t      req,                 // HSEL, HTRANS, HADDR[31:10]

    // Output stages
    input  matrix_pkg::sel_vec_t       active_in,           // Active level per stage
    input  matrix_pkg::slave_rsp_vec_t slave_rsp,           // HREADYOUT, HRESP, HRDATA

    // Address phase outputs
    output matrix_pkg::sel_vec_t       sel,                 // HSEL per output port
    output logic                       active,

    // Data phase outputs to the input stage
    output logic                       HREADYOUTS,
    output matrix_pkg::hresp_t         HRESPS,
    output logic [31:0]                HRDATAS
);

    import matrix_pkg::*;

    // ------------------------------
    // Internal wires
    // ------------------------------
    port_idx_t  addr_port;          // Address-phase port
    port_idx_t  data_port;          // Registered data-phase port
    logic       dflt_sel;           // HSEL of the default slave
    slave_rsp_t dflt_rsp;           // Default slave return

    // Address map, remap and idle hold
    addr_region_decode #(
        .REMAP_PORT (REMAP_PORT)
    ) addr_region_decode_inst (
        .remap      (remap),
        .req        (req),
        .data_port  (data_port),
        .active_in  (active_in),
        .addr_port  (addr_port),
        .sel        (sel),
        .dflt_sel   (dflt_sel),
        .active     (active)
    );

    // Unmapped addresses land here
    matrix_default_slave matrix_default_slave_inst (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .dflt_sel   (dflt_sel),
        .HREADYS    (HREADYS),
        .trans      (req.trans),
        .dflt_rsp   (dflt_rsp)
    );

    // ------------------------------
    // Data phase
    // ------------------------------
    data_phase_select data_phase_select_inst (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HREADYS    (HREADYS),
        .req_sel    (req.sel),
        .req_trans  (req.trans),
        .addr_port  (addr_port),
        .slave_rsp  (slave_rsp),
        .dflt_rsp   (dflt_rsp),
        .data_port  (data_port),    // Back to the decoder for the idle hold
        .HREADYOUTS (HREADYOUTS),
        .HRESPS     (HRESPS),
        .HRDATAS    (HRDATAS)
    );

endmodule

// File: verif/matrix_decode_checker.sv
// Samples at the falling edge and needs the driver to change inputs only just after the rising edge
`timescale 1ns/1ps

module matrix_decode_checker #(
    parameter int REMAP_PORT = 1                            // Must match the DUT
) (
    input  logic                       HCLK,
    input  logic                       HRESETn,
    input  logic                       remap,
    input  logic                       HREADYS,
    input  matrix_pkg::addr_req_t      req,
    input  matrix_pkg::sel_vec_t       active_in,
    input  matrix_pkg::slave_rsp_vec_t slave_rsp,
    input  matrix_pkg::sel_vec_t       sel,
    input  logic                       active,
    input  logic                       HREADYOUTS,
    input  matrix_pkg::hresp_t         HRESPS,
    input  logic [31:0]                HRDATAS,
    input  int                         test_id,
    input  logic                       done,
    output int                         fail_tests,
    output logic                       report_done
);

    import matrix_pkg::*;

    int   mdl_port;                 // Data-phase register copy, 8 is the default slave
    logic mdl_wait;                 // Default slave in its ready-low ERROR cycle
    logic mdl_err;                  // Default slave in either ERROR cycle
    int   cur_test;
    int   checks;
    int   errs;
    int   num_tests;
    int   err_rsp_seen;             // Default-slave wait cycles observed

    // Reference address map, 1 KB units
    function automatic int map_port(input logic [21:0] a, input logic rm);
        if (rm && a <= 22'h03ffff) return REMAP_PORT;
        if (a <= 22'h07ffff) return 0;
        if (a <= 22'h0bffff) return 1;
        if (a <= 22'h0fffff) return 2;
        if (a <= 22'h17ffff) return 3;
        if (a <= 22'h1fffff) return 6;
        if (a <= 22'h23ffff) return 4;
        if (a <= 22'h27ffff) return 5;
        if (a <= 22'h37ffff) return 6;
        if (a >= 22'h3c0000 && a <= 22'h3c00ff) return 7;
        return 8;                                           // Unmapped
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            errs++;
            $display("[FAIL] time %0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic close_test();
        num_tests++;
        if (errs != 0)
            fail_tests++;
        $display("test %0d finished: %0d checks, %0d mismatches", cur_test, checks, errs);
        checks = 0;
        errs   = 0;
    endtask

    initial
    begin
        fail_tests   = 0;
        report_done  = 1'b0;
        cur_test     = 0;
        checks       = 0;
        errs         = 0;
        num_tests    = 0;
        err_rsp_seen = 0;
        mdl_port     = 8;
        mdl_wait     = 1'b0;
        mdl_err      = 1'b0;
    end

    // ------------------------------
    // Compare, then advance the model
    // ------------------------------
    always @(negedge HCLK)
    begin
        int          ap;
        logic        real_t;
        logic        start;
        logic [7:0]  exp_sel;
        logic        exp_ready;
        logic [1:0]  exp_resp;
        logic [31:0] exp_rdata;
        real_t    = req.trans[1];                           // NONSEQ or SEQ
        ap        = real_t ? map_port(req.addr, remap) : mdl_port;    // Idle hold
        exp_sel   = (req.sel && ap < 8) ? 8'(1 << ap) : 8'h00;
        exp_ready = ~mdl_wait;
        exp_resp  = mdl_err ? 2'b01 : 2'b00;
        exp_rdata = '0;
        if (mdl_port < 8)
        begin
            exp_ready = slave_rsp[mdl_port].ready;
            exp_resp  = slave_rsp[mdl_port].resp;
            exp_rdata = slave_rsp[mdl_port].rdata;
        end
        if (done && !report_done)
        begin
            close_test();
            if (err_rsp_seen == 0)
            begin
                $display("The default slave never gave its ERROR response");
                fail_tests++;
            end
            $display("summary: %0d tests, %0d passed, %0d failed",
                     num_tests, num_tests - fail_tests, fail_tests);
            report_done = 1'b1;
        end
        else if (test_id != 0 && HRESETn)
        begin
            if (test_id != cur_test)
            begin
                if (cur_test != 0)
                    close_test();
                cur_test = test_id;
            end
            compare("sel", 32'(exp_sel), 32'(sel));
            compare("active", 32'((ap < 8) ? active_in[ap & 7] : 1'b1), 32'(active));
            compare("HREADYOUTS", 32'(exp_ready), 32'(HREADYOUTS));
            compare("HRESPS", 32'(exp_resp), 32'(HRESPS));
            compare("HRDATAS", exp_rdata, HRDATAS);
            if (mdl_port == 8 && mdl_wait)
                err_rsp_seen++;
        end
        if (!HRESETn)
        begin
            mdl_port = 8;
            mdl_wait = 1'b0;
            mdl_err  = 1'b0;
        end
        else
        begin
            start    = req.sel && (ap >= 8) && HREADYS && real_t;
            mdl_err  = start || mdl_wait;                   // Second cycle follows the wait
            mdl_wait = start;
            if (HREADYS)
                mdl_port = (req.sel && real_t) ? ap : 8;
        end
    end

endmodule

// File: verif/tb_matrix_decode.sv
// Six random phases from one fixed seed; HREADYS follows HREADYOUTS as on a single-layer bus
`timescale 1ns/1ps

module tb_matrix_decode;

    import matrix_pkg::*;

    // ------------------------------
    // Run constants
    // ------------------------------
    localparam int        CLK_PERIOD = 40;
    localparam int        RST_CYCLES = 8;
    localparam int        DRIVE_DLY  = 2;                   // Skew after the rising edge
    localparam int        NUM_TESTS  = 6;
    localparam int        TEST_LEN [NUM_TESTS] = '{8, 400, 400, 300, 400, 300};
    localparam port_idx_t REMAP_PORT = 4'd1;

    // Region bounds for address picks, 1 KB units
    localparam logic [31:0] PICK_LO [9] = '{32'h000000, 32'h080000, 32'h0c0000, 32'h100000,
        32'h180000, 32'h200000, 32'h240000, 32'h280000, 32'h3c0000};
    localparam logic [31:0] PICK_HI [9] = '{32'h07ffff, 32'h0bffff, 32'h0fffff, 32'h17ffff,
        32'h1fffff, 32'h23ffff, 32'h27ffff, 32'h37ffff, 32'h3c00ff};

    logic           HCLK;
    logic           HRESETn;
    logic           remap;
    logic           HREADYS;
    addr_req_t      req;
    sel_vec_t       active_in;
    slave_rsp_vec_t slave_rsp;
    sel_vec_t       sel;
    logic           active;
    logic           HREADYOUTS;
    hresp_t         HRESPS;
    logic [31:0]    HRDATAS;
    int             test_id;                                // 0 while in reset
    logic           done;
    int             fail_tests;
    logic           report_done;

    matrix_decode #(
        .REMAP_PORT (REMAP_PORT)
    ) matrix_decode_inst (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .remap      (remap),
        .HREADYS    (HREADYS),
        .req        (req),
        .active_in  (active_in),
        .slave_rsp  (slave_rsp),
        .sel        (sel),
        .active     (active),
        .HREADYOUTS (HREADYOUTS),
        .HRESPS     (HRESPS),
        .HRDATAS    (HRDATAS)
    );

    matrix_decode_checker #(
        .REMAP_PORT (int'(REMAP_PORT))
    ) checker_inst (.*);

    initial
    begin
        HCLK = 1'b0;
        forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
    end

    // Mode 1 leans on the remap window, mode 2 on the gap above region 6b
    function automatic dec_addr_t pick_addr(input int mode);
        int r;
        r = int'($urandom % 9);
        if (mode == 1 && $urandom % 2 == 0)
            return dec_addr_t'($urandom % 32'h40000);
        if (mode == 2 && $urandom % 4 != 0)
            return dec_addr_t'(32'h380000 + $urandom % 32'h80000);
        if ($urandom % 2 == 0)
            return dec_addr_t'(PICK_LO[r] + $urandom % (PICK_HI[r] - PICK_LO[r] + 1));
        return dec_addr_t'($urandom);                       // Uniform over all 22 bits
    endfunction

    // ------------------------------
    // One cycle of stimulus
    // ------------------------------
    task automatic drive_cycle(input int id);
        @(posedge HCLK);
        #DRIVE_DLY;
        test_id   = id;
        remap     = (id == 3) ? 1'b1 : (id <= 2) ? 1'b0 : 1'($urandom % 2);
        req.sel   = (id == 1) ? 1'b0 : 1'($urandom % 8 != 0);
        case (id)
            2, 3, 6: req.trans = htrans_t'(($urandom % 8 == 0) ? $urandom % 2 : 2 + $urandom % 2);
            4:       req.trans = htrans_t'(($urandom % 4 == 0) ? 2 + $urandom % 2 : $urandom % 2);
            default: req.trans = htrans_t'($urandom % 4);
        endcase
        req.addr  = pick_addr((id == 3) ? 1 : (id == 6) ? 2 : 0);
        active_in = sel_vec_t'($urandom);
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            slave_rsp[i].ready = 1'($urandom % 4 != 0);     // Mostly zero wait
            slave_rsp[i].resp  = hresp_t'($urandom % 2);
            slave_rsp[i].rdata = $urandom;
        end
        #1 HREADYS = HREADYOUTS;                            // Return settled by now
    endtask

    initial
    begin
        void'($urandom(32'h4fd6_89b0));
        HRESETn   = 1'b0;
        remap     = 1'b0;
        HREADYS   = 1'b1;
        req       = '0;
        active_in = '0;
        slave_rsp = '0;
        test_id   = 0;
        done      = 1'b0;
        repeat (RST_CYCLES) @(posedge HCLK);
        #DRIVE_DLY HRESETn = 1'b1;
        for (int t = 1; t <= NUM_TESTS; t++)
            for (int c = 0; c < TEST_LEN[t-1]; c++)
                drive_cycle(t);
        @(posedge HCLK);
        #DRIVE_DLY done = 1'b1;
        wait (report_done);
        if (fail_tests == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Watchdog, sized from the test lengths plus a margin
    initial
    begin
        int limit;
        limit = RST_CYCLES + 50;
        for (int t = 0; t < NUM_TESTS; t++)
            limit += TEST_LEN[t];
        #(limit * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: filelist.f
src/matrix_pkg.sv
src/addr_region_decode.sv
src/matrix_default_slave.sv
src/data_phase_select.sv
src/matrix_decode.sv
verif/matrix_decode_checker.sv
verif/tb_matrix_decode.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f filelist.f \
    --top-module tb_matrix_decode \
    -Mdir obj_dir \
    -o sim_matrix_decode

./obj_dir/sim_matrix_decode > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
